// ==== filelist.f ====
+incdir+design
design/serv_pkg.sv
design/serv_decode.sv
design/serv_bufreg.sv
design/serv_ctrl.sv
design/serv_alu.sv
design/serv_rf.sv
design/serv_mem_if.sv
design/serv_top.sv
verification/serv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the serv testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module serv_tb -o serv_sim \
   && ./obj_dir/serv_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
   && echo "Simulation run succeeded" \
   || { echo "Simulation run did not succeed"; exit 1; }

// ==== verification/serv_tb.sv ====
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_tb import serv_pkg::*; ();

   localparam int HALT_LIMIT = 8000;

   logic      clk = 1'b0;
   logic      i_rst_n = 1'b0;
   ibus_req_t ibus_req;
   bus_rsp_t  ibus_rsp = '0;
   dbus_req_t dbus_req;
   bus_rsp_t  dbus_rsp = '0;

   word_t imem [0:255];
   word_t dmem [0:255];
   word_t fetch_log [$];
   word_t store_adr [$];
   word_t store_dat [$];
   word_t prog_pc;
   int    fetch_base = 0;
   int    store_base = 0;
   int    ibus_wait = 0;
   int    dbus_wait = 0;
   int    data_errors = 0;
   int    addr_errors = 0;
   int    other_errors = 0;

   serv_top uut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus     (ibus_req),
      .i_ibus_rsp (ibus_rsp),
      .o_dbus     (dbus_req),
      .i_dbus_rsp (dbus_rsp)
   );

   always #4 clk = ~clk;

   // Instruction memory answers after 0 to 3 idle cycles
   always @(negedge clk) begin
      if (!i_rst_n) begin
         ibus_rsp.ack = 1'b0;
      end else if (ibus_rsp.ack) begin
         ibus_rsp.ack = 1'b0;
      end else if (ibus_req.cyc) begin
         if (ibus_wait == 0) begin
            ibus_rsp.rdt = imem[ibus_req.adr[9:2]];
            ibus_rsp.ack = 1'b1;
            fetch_log.push_back(ibus_req.adr);
            ibus_wait = $urandom % 4;
         end else begin
            ibus_wait--;
         end
      end
   end

   // Data memory, refilled while reset is held
   always @(negedge clk) begin
      if (!i_rst_n) begin
         dbus_rsp.ack = 1'b0;
         for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd0d0_0000 | (32'(i) << 2);
         end
      end else if (dbus_rsp.ack) begin
         dbus_rsp.ack = 1'b0;
      end else if (dbus_req.cyc) begin
         if (dbus_wait == 0) begin
            // Every access is a full word
            check_sel("dbus sel", dbus_req.sel, 4'b1111);
            if (dbus_req.we) begin
               dmem[dbus_req.adr[9:2]] = dbus_req.dat;
               store_adr.push_back(dbus_req.adr);
               store_dat.push_back(dbus_req.dat);
            end else begin
               dbus_rsp.rdt = dmem[dbus_req.adr[9:2]];
            end
            dbus_rsp.ack = 1'b1;
            dbus_wait = $urandom % 4;
         end else begin
            dbus_wait--;
         end
      end
   end

   function automatic word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic word_t imm_format(input logic [11:0] imm, input reg_addr_t rs1,
                                        input funct3_t f3, input reg_addr_t rd,
                                        input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t reg_format(input logic [6:0] f7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input funct3_t f3,
                                        input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, `SERV_OP_OP};
   endfunction

   function automatic word_t store_format(input logic [11:0] off, input reg_addr_t rs2,
                                          input reg_addr_t rs1);
      return {off[11:5], rs2, rs1, `SERV_F3_W, off[4:0], `SERV_OP_STORE};
   endfunction

   function automatic word_t branch_format(input logic [12:0] off, input reg_addr_t rs2,
                                           input reg_addr_t rs1, input funct3_t f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `SERV_OP_BRANCH};
   endfunction

   function automatic word_t upper_format(input logic [19:0] imm, input reg_addr_t rd);
      return {imm, rd, `SERV_OP_LUI};
   endfunction

   function automatic word_t jump_format(input logic [20:0] off, input reg_addr_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, `SERV_OP_JAL};
   endfunction

   task automatic emit(input word_t instr);
      imem[prog_pc[9:2]] = instr;
      prog_pc = prog_pc + 32'd4;
   endtask

   // Unknown opcode 7f in every filler word, so stray fetches do nothing
   task automatic hold_reset();
      @(negedge clk);
      i_rst_n = 1'b0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = {i[24:0], 7'h7f};
      end
      prog_pc = `SERV_RESET_PC;
      repeat (2) @(negedge clk);
      if (ibus_req.cyc || dbus_req.cyc) begin
         $display("Error at %0t: a bus cycle is active during reset", $time);
         other_errors++;
      end
   endtask

   task automatic release_reset();
      fetch_base = fetch_log.size();
      store_base = store_adr.size();
      i_rst_n = 1'b1;
   endtask

   task automatic wait_halt(input word_t pc);
      int cycles;
      int hits;
      cycles = 0;
      hits = 0;
      while (hits < 2 && cycles < HALT_LIMIT) begin
         @(posedge clk);
         cycles++;
         hits = 0;
         for (int i = fetch_base; i < fetch_log.size(); i++) begin
            if (fetch_log[i] == pc) begin
               hits++;
            end
         end
      end
      if (hits < 2) begin
         $display("Error at %0t: program never reached its halt loop at %h", $time, pc);
         other_errors++;
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         data_errors++;
      end
   endtask

   task automatic check_addr(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         addr_errors++;
      end
   endtask

   task automatic check_sel(input string name, input logic [`SERV_SEL_W-1:0] got,
                            input logic [`SERV_SEL_W-1:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         addr_errors++;
      end
   endtask

   task automatic check_store(input int idx, input word_t adr, input word_t dat,
                              input string name);
      if (store_base + idx >= store_adr.size()) begin
         $display("Error at %0t: store of %s never appeared on dbus", $time, name);
         other_errors++;
      end else begin
         check_addr({name, " store address"}, store_adr[store_base + idx], adr);
         check_word({name, " store data"}, store_dat[store_base + idx], dat);
      end
   endtask

   task automatic check_fetch(input int idx, input word_t adr);
      if (fetch_base + idx >= fetch_log.size()) begin
         $display("Error at %0t: fetch number %0d never happened", $time, idx);
         other_errors++;
      end else begin
         check_addr("ibus fetch address", fetch_log[fetch_base + idx], adr);
      end
   endtask

   task automatic fetch_order();
      hold_reset();
      for (int i = 0; i < 4; i++) begin
         emit(imm_format(12'd1, 5'd0, `SERV_F3_ADD, 5'd1, `SERV_OP_OPIMM));
      end
      emit(jump_format(21'd0, 5'd0));
      release_reset();
      wait_halt(`SERV_RESET_PC + 32'd16);
      for (int i = 0; i < 6; i++) begin
         check_fetch(i, `SERV_RESET_PC + 32'(4 * (i < 5 ? i : 4)));
      end
   endtask

   task automatic alu_results();
      word_t       rnd;
      logic [11:0] imm_a;
      logic [11:0] imm_b;
      logic [19:0] upper;
      word_t       a;
      word_t       b;
      word_t       halt;
      rnd = $urandom;
      imm_a = rnd[11:0];
      rnd = $urandom;
      imm_b = rnd[11:0];
      rnd = $urandom;
      upper = rnd[19:0];
      a = sext12(imm_a);
      b = sext12(imm_b);
      hold_reset();
      emit(imm_format(imm_a, 5'd0, `SERV_F3_ADD, 5'd1, `SERV_OP_OPIMM));
      emit(imm_format(imm_b, 5'd0, `SERV_F3_ADD, 5'd2, `SERV_OP_OPIMM));
      emit(reg_format(7'b0000000, 5'd2, 5'd1, `SERV_F3_ADD, 5'd3));
      emit(store_format(12'h100, 5'd3, 5'd0));
      emit(reg_format(7'b0100000, 5'd2, 5'd1, `SERV_F3_ADD, 5'd4));
      emit(store_format(12'h104, 5'd4, 5'd0));
      emit(reg_format(7'b0000000, 5'd2, 5'd1, `SERV_F3_AND, 5'd5));
      emit(store_format(12'h108, 5'd5, 5'd0));
      emit(reg_format(7'b0000000, 5'd2, 5'd1, `SERV_F3_OR, 5'd6));
      emit(store_format(12'h10c, 5'd6, 5'd0));
      emit(reg_format(7'b0000000, 5'd2, 5'd1, `SERV_F3_XOR, 5'd7));
      emit(store_format(12'h110, 5'd7, 5'd0));
      emit(imm_format(imm_b, 5'd1, `SERV_F3_ADD, 5'd8, `SERV_OP_OPIMM));
      emit(store_format(12'h114, 5'd8, 5'd0));
      emit(imm_format(imm_b, 5'd1, `SERV_F3_XOR, 5'd9, `SERV_OP_OPIMM));
      emit(store_format(12'h118, 5'd9, 5'd0));
      emit(upper_format(upper, 5'd10));
      emit(store_format(12'h11c, 5'd10, 5'd0));
      halt = prog_pc;
      emit(jump_format(21'd0, 5'd0));
      release_reset();
      wait_halt(halt);
      check_store(0, 32'h100, a + b, "ADD");
      check_store(1, 32'h104, a - b, "SUB");
      check_store(2, 32'h108, a & b, "AND");
      check_store(3, 32'h10c, a | b, "OR");
      check_store(4, 32'h110, a ^ b, "XOR");
      check_store(5, 32'h114, a + b, "ADDI");
      check_store(6, 32'h118, a ^ b, "XORI");
      check_store(7, 32'h11c, {upper, 12'h000}, "LUI");
   endtask

   task automatic load_store_roundtrip();
      word_t       rnd;
      logic [19:0] upper;
      logic [11:0] low;
      word_t       value;
      word_t       halt;
      rnd = $urandom;
      upper = rnd[31:12];
      low = rnd[11:0];
      value = {upper, 12'h000} + sext12(low);
      hold_reset();
      emit(imm_format(12'h200, 5'd0, `SERV_F3_ADD, 5'd1, `SERV_OP_OPIMM));
      emit(upper_format(upper, 5'd2));
      emit(imm_format(low, 5'd2, `SERV_F3_ADD, 5'd2, `SERV_OP_OPIMM));
      emit(store_format(12'd8, 5'd2, 5'd1));
      emit(imm_format(12'd8, 5'd1, `SERV_F3_W, 5'd3, `SERV_OP_LOAD));
      emit(store_format(12'd12, 5'd3, 5'd1));
      emit(imm_format(12'h040, 5'd1, `SERV_F3_W, 5'd4, `SERV_OP_LOAD));
      emit(store_format(12'd16, 5'd4, 5'd1));
      halt = prog_pc;
      emit(jump_format(21'd0, 5'd0));
      release_reset();
      wait_halt(halt);
      check_store(0, 32'h208, value, "SW of built word");
      check_store(1, 32'h20c, value, "reloaded word");
      check_store(2, 32'h210, 32'hd0d0_0000 | 32'h240, "preloaded word");
   endtask

   task automatic branch_jump();
      word_t exp [12];
      hold_reset();
      emit(imm_format(12'd5, 5'd0, `SERV_F3_ADD, 5'd5, `SERV_OP_OPIMM));
      emit(imm_format(12'd5, 5'd0, `SERV_F3_ADD, 5'd2, `SERV_OP_OPIMM));
      emit(branch_format(13'd8, 5'd2, 5'd5, `SERV_F3_BEQ));
      emit(imm_format(12'd1, 5'd0, `SERV_F3_ADD, 5'd5, `SERV_OP_OPIMM));
      emit(branch_format(13'd8, 5'd2, 5'd5, `SERV_F3_BNE));
      emit(imm_format(12'd7, 5'd0, `SERV_F3_ADD, 5'd3, `SERV_OP_OPIMM));
      emit(branch_format(13'd12, 5'd3, 5'd5, `SERV_F3_BNE));
      emit(imm_format(12'd2, 5'd0, `SERV_F3_ADD, 5'd5, `SERV_OP_OPIMM));
      emit(imm_format(12'd2, 5'd0, `SERV_F3_ADD, 5'd5, `SERV_OP_OPIMM));
      emit(branch_format(13'd8, 5'd3, 5'd5, `SERV_F3_BEQ));
      emit(jump_format(21'd12, 5'd6));
      emit(imm_format(12'd3, 5'd0, `SERV_F3_ADD, 5'd5, `SERV_OP_OPIMM));
      emit(imm_format(12'd3, 5'd0, `SERV_F3_ADD, 5'd5, `SERV_OP_OPIMM));
      emit(store_format(12'h300, 5'd6, 5'd0));
      emit(store_format(12'h304, 5'd5, 5'd0));
      emit(jump_format(21'd0, 5'd0));
      release_reset();
      wait_halt(32'd60);
      // Taken goes to pc plus offset, otherwise pc plus 4
      exp = '{32'd0, 32'd4, 32'd8, 32'd8 + 32'd8, 32'd16 + 32'd4, 32'd20 + 32'd4,
              32'd24 + 32'd12, 32'd36 + 32'd4, 32'd40 + 32'd12, 32'd52 + 32'd4,
              32'd56 + 32'd4, 32'd60};
      for (int i = 0; i < 12; i++) begin
         check_fetch(i, exp[i]);
      end
      check_store(0, 32'h300, 32'd40 + 32'd4, "JAL link");
      check_store(1, 32'h304, 32'd5, "skipped register");
   endtask

   task automatic zero_register();
      word_t halt;
      hold_reset();
      emit(imm_format(12'h3c5, 5'd0, `SERV_F3_ADD, 5'd1, `SERV_OP_OPIMM));
      emit(imm_format(12'h123, 5'd0, `SERV_F3_ADD, 5'd0, `SERV_OP_OPIMM));
      emit(reg_format(7'b0000000, 5'd1, 5'd1, `SERV_F3_ADD, 5'd0));
      emit(upper_format(20'habcde, 5'd0));
      emit(store_format(12'h310, 5'd0, 5'd0));
      emit(store_format(12'h314, 5'd1, 5'd0));
      halt = prog_pc;
      emit(jump_format(21'd0, 5'd0));
      release_reset();
      wait_halt(halt);
      check_store(0, 32'h310, 32'd0, "x0");
      check_store(1, 32'h314, sext12(12'h3c5), "x1");
   endtask

   initial begin
      void'($urandom(32'hc71c_ca3f));
      fetch_order();
      alu_results();
      load_store_roundtrip();
      branch_jump();
      zero_register();
      $display("Error counts: %0d data, %0d address, %0d other",
               data_errors, addr_errors, other_errors);
      if (data_errors + addr_errors + other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== design/serv_top.sv ====
`timescale 1ns/1ps

module serv_top import serv_pkg::*; (
   input  logic      clk,
   input  logic      i_rst_n,
   output ibus_req_t o_ibus,
   input  bus_rsp_t  i_ibus_rsp,
   output dbus_req_t o_dbus,
   input  bus_rsp_t  i_dbus_rsp
);

   seq_state_e state;
   cnt_t       cnt;
   logic       cnt_en;
   logic       init;
   alu_op_e    alu_op;
   logic       imm;
   logic       op_b_imm;
   reg_addr_t  rd_addr;
   reg_addr_t  rs1_addr;
   reg_addr_t  rs2_addr;
   logic       rd_en;
   logic [1:0] rd_sel;
   logic       take_branch;
   logic       mem_we;
   logic       mem_req;
   logic       alu_eq;
   logic       alu_rd;
   logic       mem_rd;
   logic       rs1;
   logic       rs2;
   logic       rd;
   logic       op_b;
   logic       link;
   logic       fetch;
   logic       buf_rs1;
   logic       buf_imm;
   logic       buf_q;
   word_t      buf_word;

   assign fetch = (state == IDLE);
   assign link  = rd_sel[1];

   assign op_b = op_b_imm ? imm : rs2;

   // JAL link value is PC plus four, summed in the buffer register
   assign buf_rs1 = link ? o_ibus.adr[0] : rs1;
   assign buf_imm = link ? (cnt == 5'd2) : imm;

   assign rd = link      ? buf_q  :
               rd_sel[0] ? mem_rd :
                           alu_rd;

   serv_decode decode (
      .i_clk         (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_rsp    (i_ibus_rsp),
      .i_dbus_ack    (i_dbus_rsp.ack),
      .i_alu_eq      (alu_eq),
      .o_state       (state),
      .o_cnt         (cnt),
      .o_cnt_en      (cnt_en),
      .o_init        (init),
      .o_alu_op      (alu_op),
      .o_imm         (imm),
      .o_op_b_imm    (op_b_imm),
      .o_rd_addr     (rd_addr),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_en       (rd_en),
      .o_rd_sel      (rd_sel),
      .o_take_branch (take_branch),
      .o_mem_we      (mem_we),
      .o_mem_req     (mem_req)
   );

   serv_bufreg bufreg (
      .i_clk    (clk),
      .i_rst_n  (i_rst_n),
      .i_cnt_en (cnt_en),
      .i_clr    (init),
      .i_rs1    (buf_rs1),
      .i_imm    (buf_imm),
      .o_q      (buf_q),
      .o_word   (buf_word)
   );

   serv_ctrl ctrl (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_imm      (imm),
      .i_jump     (take_branch),
      .i_fetch    (fetch),
      .i_ibus_ack (i_ibus_rsp.ack),
      .o_ibus     (o_ibus)
   );

   serv_alu alu (
      .i_clk    (clk),
      .i_rst_n  (i_rst_n),
      .i_cnt_en (cnt_en),
      .i_init   (init),
      .i_rs1    (rs1),
      .i_op_b   (op_b),
      .i_op     (alu_op),
      .o_rd     (alu_rd),
      .o_eq     (alu_eq)
   );

   serv_rf rf (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (rd_en),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_mem_if mem_if (
      .i_clk      (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_req      (mem_req),
      .i_we       (mem_we),
      .i_adr      (buf_word),
      .i_rs2      (rs2),
      .i_dbus_rsp (i_dbus_rsp),
      .o_dbus     (o_dbus),
      .o_rd       (mem_rd)
   );

endmodule

// ==== design/serv_mem_if.sv ====
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_mem_if import serv_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst_n,
   input  logic      i_cnt_en,
   input  logic      i_req,
   input  logic      i_we,
   input  word_t     i_adr,
   input  logic      i_rs2,
   input  bus_rsp_t  i_dbus_rsp,
   output dbus_req_t o_dbus,
   output logic      o_rd
);

   word_t dat_q;
   logic  cyc_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cyc_q <= 1'b0;
      end else if (i_dbus_rsp.ack) begin
         cyc_q <= 1'b0;
      end else if (i_req) begin
         cyc_q <= 1'b1;
      end
   end

   // Store data shifts in during the first run, load data out during the second
   always_ff @(posedge i_clk) begin
      if (cyc_q && i_dbus_rsp.ack && !i_we) begin
         dat_q <= i_dbus_rsp.rdt;
      end else if (i_cnt_en) begin
         dat_q <= {i_rs2, dat_q[31:1]};
      end
   end

   assign o_dbus.adr = i_adr;
   assign o_dbus.dat = dat_q;
   assign o_dbus.sel = `SERV_SEL_ALL;
   assign o_dbus.we  = i_we;
   assign o_dbus.cyc = cyc_q;
   assign o_rd       = dat_q[0];

   a_dbus_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_dbus.cyc && !i_dbus_rsp.ack) |=>
         (o_dbus.cyc && $stable(o_dbus.adr) && $stable(o_dbus.dat)));

endmodule

// ==== design/serv_rf.sv ====
`timescale 1ns/1ps

module serv_rf import serv_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst_n,
   input  logic      i_cnt_en,
   input  cnt_t      i_cnt,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   input  reg_addr_t i_rd_addr,
   input  logic      i_rd_en,
   input  logic      i_rd,
   output logic      o_rs1,
   output logic      o_rs2
);

   word_t regs [0:31];

   always_ff @(posedge i_clk) begin
      if (i_cnt_en && i_rd_en && (i_rd_addr != '0)) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   assign o_rs1 = (i_rs1_addr == '0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == '0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

endmodule

// ==== design/serv_alu.sv ====
`timescale 1ns/1ps

module serv_alu import serv_pkg::*; (
   input  logic    i_clk,
   input  logic    i_rst_n,
   input  logic    i_cnt_en,
   input  logic    i_init,
   input  logic    i_rs1,
   input  logic    i_op_b,
   input  alu_op_e i_op,
   output logic    o_rd,
   output logic    o_eq
);

   logic carry;
   logic ne_q;
   logic b;
   logic sum;

   // Subtraction adds the inverted operand plus one
   assign b   = (i_op == ALU_SUB) ? ~i_op_b : i_op_b;
   assign sum = i_rs1 ^ b ^ carry;

   always_comb begin
      case (i_op)
         ALU_AND:  o_rd = i_rs1 & i_op_b;
         ALU_OR:   o_rd = i_rs1 | i_op_b;
         ALU_XOR:  o_rd = i_rs1 ^ i_op_b;
         ALU_PASS: o_rd = i_op_b;
         default:  o_rd = sum;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
         ne_q  <= 1'b0;
      end else if (i_init) begin
         carry <= (i_op == ALU_SUB);
         ne_q  <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= (i_rs1 & b) | (i_rs1 & carry) | (b & carry);
         // Any differing bit sticks
         ne_q  <= ne_q | (i_rs1 ^ i_op_b);
      end
   end

   assign o_eq = ~ne_q;

endmodule

// ==== design/serv_ctrl.sv ====
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_ctrl import serv_pkg::*; (
   input  logic      i_clk,
   input  logic      i_rst_n,
   input  logic      i_cnt_en,
   input  cnt_t      i_cnt,
   input  logic      i_imm,
   input  logic      i_jump,
   input  logic      i_fetch,
   input  logic      i_ibus_ack,
   output ibus_req_t o_ibus
);

   word_t pc;
   word_t tgt;
   logic  pc_en;
   logic  c_inc;
   logic  c_tgt;
   logic  cyc_q;
   logic  inc_bit;
   logic  sum_inc;
   logic  sum_tgt;

   // Serial constant four
   assign inc_bit = (i_cnt == 5'd2);
   assign sum_inc = pc[0] ^ inc_bit ^ c_inc;
   assign sum_tgt = pc[0] ^ i_imm ^ c_tgt;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc    <= `SERV_RESET_PC;
         pc_en <= 1'b0;
         c_inc <= 1'b0;
         c_tgt <= 1'b0;
         cyc_q <= 1'b0;
      end else begin
         if (i_fetch) begin
            pc_en <= 1'b1;
            c_inc <= 1'b0;
            c_tgt <= 1'b0;
            if (i_jump) begin
               pc <= tgt;
            end
         end else if (pc_en && i_cnt_en) begin
            pc    <= {sum_inc, pc[31:1]};
            c_inc <= (pc[0] & inc_bit) | (pc[0] & c_inc) | (inc_bit & c_inc);
            c_tgt <= (pc[0] & i_imm) | (pc[0] & c_tgt) | (i_imm & c_tgt);
            // Only the first run of an instruction moves the PC
            if (i_cnt == 5'd31) begin
               pc_en <= 1'b0;
            end
         end
         if (i_ibus_ack) begin
            cyc_q <= 1'b0;
         end else if (i_fetch) begin
            cyc_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (pc_en && i_cnt_en) begin
         tgt <= {sum_tgt, tgt[31:1]};
      end
   end

   assign o_ibus.adr = pc;
   assign o_ibus.cyc = cyc_q;

   a_ibus_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_ibus.cyc && !i_ibus_ack) |=> (o_ibus.cyc && $stable(o_ibus.adr)));

endmodule

// ==== design/serv_bufreg.sv ====
`timescale 1ns/1ps

module serv_bufreg import serv_pkg::*; (
   input  logic  i_clk,
   input  logic  i_rst_n,
   input  logic  i_cnt_en,
   input  logic  i_clr,
   input  logic  i_rs1,
   input  logic  i_imm,
   output logic  o_q,
   output word_t o_word
);

   word_t data;
   logic  carry;
   logic  sum;

   assign sum = i_rs1 ^ i_imm ^ carry;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else if (i_clr) begin
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= (i_rs1 & i_imm) | (i_rs1 & carry) | (i_imm & carry);
      end
   end

   // Sum enters at the top, full word after 32 bits
   always_ff @(posedge i_clk) begin
      if (i_cnt_en) begin
         data <= {sum, data[31:1]};
      end
   end

   assign o_q    = sum;
   assign o_word = data;

endmodule

// ==== design/serv_decode.sv ====
`timescale 1ns/1ps
`include "serv_defs.svh"

module serv_decode import serv_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  bus_rsp_t    i_ibus_rsp,
   input  logic        i_dbus_ack,
   input  logic        i_alu_eq,
   output seq_state_e  o_state,
   output cnt_t        o_cnt,
   output logic        o_cnt_en,
   output logic        o_init,
   output alu_op_e     o_alu_op,
   output logic        o_imm,
   output logic        o_op_b_imm,
   output reg_addr_t   o_rd_addr,
   output reg_addr_t   o_rs1_addr,
   output reg_addr_t   o_rs2_addr,
   output logic        o_rd_en,
   output logic [1:0]  o_rd_sel,
   output logic        o_take_branch,
   output logic        o_mem_we,
   output logic        o_mem_req
);

   seq_state_e state;
   cnt_t       cnt;
   word_t      ir;
   word_t      imm_q;
   word_t      imm_word;
   logic       second_q;
   logic [6:0] opcode;
   funct3_t    funct3;
   logic       is_lui;
   logic       is_jal;
   logic       is_branch;
   logic       is_load;
   logic       is_store;
   logic       is_opimm;
   logic       is_op;
   logic       is_mem;
   logic       alu_f3_ok;
   logic       op_ok;
   logic       wr_rd;
   logic       run_last;

   assign opcode    = ir[6:0];
   assign funct3    = ir[14:12];
   assign is_lui    = (opcode == `SERV_OP_LUI);
   assign is_jal    = (opcode == `SERV_OP_JAL);
   assign is_branch = (opcode == `SERV_OP_BRANCH);
   assign is_load   = (opcode == `SERV_OP_LOAD) && (funct3 == `SERV_F3_W);
   assign is_store  = (opcode == `SERV_OP_STORE) && (funct3 == `SERV_F3_W);
   assign is_opimm  = (opcode == `SERV_OP_OPIMM);
   assign is_op     = (opcode == `SERV_OP_OP);
   assign is_mem    = is_load || is_store;

   assign alu_f3_ok = (funct3 == `SERV_F3_ADD) || (funct3 == `SERV_F3_XOR) ||
                      (funct3 == `SERV_F3_OR)  || (funct3 == `SERV_F3_AND);
   // Only SUB may set funct7 bit 5
   assign op_ok = (ir[31:25] == 7'b0000000) ||
                  ((ir[31:25] == 7'b0100000) && (funct3 == `SERV_F3_ADD));
   assign wr_rd = (is_opimm && alu_f3_ok) || (is_op && alu_f3_ok && op_ok) ||
                  is_lui || is_jal;

   assign run_last = (state == RUN) && (cnt == 5'd31);

   always_comb begin
      case (opcode)
         `SERV_OP_STORE:  imm_word = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         `SERV_OP_BRANCH: imm_word = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
         `SERV_OP_LUI:    imm_word = {ir[31:12], 12'b0};
         `SERV_OP_JAL:    imm_word = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
         default:         imm_word = {{20{ir[31]}}, ir[31:20]};
      endcase
   end

   always_comb begin
      if (is_lui) begin
         o_alu_op = ALU_PASS;
      end else if (is_branch) begin
         o_alu_op = ALU_SUB;
      end else begin
         case (funct3)
            `SERV_F3_XOR: o_alu_op = ALU_XOR;
            `SERV_F3_OR:  o_alu_op = ALU_OR;
            `SERV_F3_AND: o_alu_op = ALU_AND;
            default:      o_alu_op = (is_op && ir[30]) ? ALU_SUB : ALU_ADD;
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state    <= IDLE;
         cnt      <= '0;
         ir       <= '0;
         second_q <= 1'b0;
      end else begin
         case (state)
            IDLE:  state <= FETCH;
            FETCH: begin
               if (i_ibus_rsp.ack) begin
                  ir    <= i_ibus_rsp.rdt;
                  state <= INIT;
               end
            end
            INIT:  state <= RUN;
            RUN: begin
               cnt <= cnt + 5'd1;
               if (run_last) begin
                  if (is_mem && !second_q) begin
                     state    <= MEM;
                     second_q <= 1'b1;
                  end else begin
                     state    <= IDLE;
                     second_q <= 1'b0;
                  end
               end
            end
            MEM: begin
               if (i_dbus_ack) begin
                  state <= RUN;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Immediate leaves LSB first
   always_ff @(posedge i_clk) begin
      if (state == INIT) begin
         imm_q <= imm_word;
      end else if (o_cnt_en) begin
         imm_q <= {1'b0, imm_q[31:1]};
      end
   end

   assign o_state    = state;
   assign o_cnt      = cnt;
   assign o_cnt_en   = (state == RUN);
   assign o_init     = (state == INIT);
   assign o_imm      = imm_q[0];
   assign o_op_b_imm = is_opimm || is_lui;
   assign o_rd_addr  = ir[11:7];
   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];
   // Loads write back in the run after the bus access
   assign o_rd_en    = o_cnt_en && ((wr_rd && !second_q) || (is_load && second_q));
   assign o_rd_sel   = {is_jal, is_load};
   assign o_mem_we   = is_store;
   assign o_mem_req  = run_last && is_mem && !second_q;

   // Equality flag is complete once the run is over
   assign o_take_branch = is_jal ||
                          (is_branch && (((funct3 == `SERV_F3_BEQ) && i_alu_eq) ||
                                         ((funct3 == `SERV_F3_BNE) && !i_alu_eq)));

   a_cnt_parked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (state != RUN) |-> (cnt == '0));

endmodule

// ==== design/serv_pkg.sv ====
`include "serv_defs.svh"

package serv_pkg;

   typedef logic [`SERV_XLEN-1:0]  word_t;
   typedef logic [`SERV_REG_W-1:0] reg_addr_t;
   typedef logic [`SERV_CNT_W-1:0] cnt_t;
   typedef logic [2:0]             funct3_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS
   } alu_op_e;

   // One instruction at a time walks through these
   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      INIT,
      RUN,
      MEM
   } seq_state_e;

   typedef struct packed {
      word_t adr;
      logic  cyc;
   } ibus_req_t;

   typedef struct packed {
      word_t                 adr;
      word_t                 dat;
      logic [`SERV_SEL_W-1:0] sel;
      logic                  we;
      logic                  cyc;
   } dbus_req_t;

   typedef struct packed {
      word_t rdt;
      logic  ack;
   } bus_rsp_t;

endpackage

// ==== design/serv_defs.svh ====
`ifndef SERV_DEFS_SVH
`define SERV_DEFS_SVH

// Data and index widths
`define SERV_XLEN     32
`define SERV_REG_W    5
`define SERV_CNT_W    5
`define SERV_SEL_W    4
`define SERV_SEL_ALL  4'b1111

`define SERV_RESET_PC 32'h0000_0000

// Major opcodes
`define SERV_OP_LUI    7'b0110111
`define SERV_OP_JAL    7'b1101111
`define SERV_OP_BRANCH 7'b1100011
`define SERV_OP_LOAD   7'b0000011
`define SERV_OP_STORE  7'b0100011
`define SERV_OP_OPIMM  7'b0010011
`define SERV_OP_OP     7'b0110011

// funct3 values
`define SERV_F3_ADD 3'b000
`define SERV_F3_XOR 3'b100
`define SERV_F3_OR  3'b110
`define SERV_F3_AND 3'b111
`define SERV_F3_BEQ 3'b000
`define SERV_F3_BNE 3'b001
`define SERV_F3_W   3'b010

`endif
